//--- verilog/video_pkg.sv
`default_nettype none

package video_pkg;

    // Raster geometry, kept tiny for simulation
    localparam int HTOTAL    = 24;
    localparam int HACTIVE   = 16;
    localparam int VTOTAL    = 20;
    localparam int VACTIVE   = 16;
    localparam int TILE_COLS = HACTIVE / 8;

    // Sync pulses sit inside the blanking intervals
    localparam int HS_START = 18;
    localparam int HS_END   = 20;
    localparam int VS_START = 17;
    localparam int VS_END   = 18;

    // clk cycles per pxl2_cen, pxl_cen is half that rate
    localparam int CEN_DIV = 4;
    localparam int CEN_W   = $clog2(2 * CEN_DIV);

    localparam int COL_W    = $clog2(TILE_COLS);
    localparam int LB_AW    = $clog2(HACTIVE);
    localparam int PAL_SIZE = 128;

    typedef logic [4:0] hpos_t;
    typedef logic [4:0] vpos_t;

    typedef struct packed {
        logic       hflip;
        logic [2:0] rsvd;
        logic [2:0] pal;
        logic [8:0] code;
    } map_word_t;

    typedef logic [5:0]  map_addr_t;
    // Tile code, then line inside the tile
    typedef logic [11:0] char_addr_t;
    // Leftmost pixel in the top nibble
    typedef logic [31:0] char_row_t;

    typedef struct packed {
        logic [2:0] pal;
        logic [3:0] nib;
    } pix_t;

    typedef struct packed {
        logic [4:0] b;
        logic [4:0] g;
        logic [4:0] r;
    } colour_t;

endpackage

`default_nettype wire

//--- verilog/linebuf_if.sv
`default_nettype none

// Pixel path from the fetcher through the line buffer to the mixer
interface linebuf_if import video_pkg::*; ();

    logic  wr_en;
    hpos_t wr_addr;
    pix_t  wr_pix;
    hpos_t rd_addr;
    // Valid one clk after rd_addr
    pix_t  rd_pix;

    modport writer (
        output wr_en, wr_addr, wr_pix
    );

    modport reader (
        output rd_addr,
        input  rd_pix
    );

    modport store (
        input  wr_en, wr_addr, wr_pix, rd_addr,
        output rd_pix
    );

endinterface

`default_nettype wire

//--- verilog/video_cen.sv
`default_nettype none

module video_cen import video_pkg::*; (
    input  wire  clk,
    input  wire  reset,
    output logic pxl2_cen,
    output logic pxl_cen
);

    logic [CEN_W-1:0] cnt;

    // Free-running divider, both enables are single clk pulses
    always_ff @(posedge clk) begin
        if (reset) begin
            cnt      <= '0;
            pxl2_cen <= 1'b0;
            pxl_cen  <= 1'b0;
        end else begin
            cnt      <= cnt + 1'b1;
            pxl2_cen <= cnt[CEN_W-2:0] == (CEN_W-1)'(CEN_DIV - 1);
            // Every second pxl2_cen
            pxl_cen  <= cnt == CEN_W'(CEN_DIV - 1);
        end
    end

endmodule

`default_nettype wire

//--- verilog/video_timing.sv
`default_nettype none

module video_timing import video_pkg::*; (
    input  wire   clk,
    input  wire   reset,
    input  wire   pxl_cen,
    output hpos_t hdump,
    output vpos_t vdump,
    output vpos_t vrender,
    output logic  hstart,
    output logic  LHBL,
    output logic  LVBL,
    output logic  HS,
    output logic  VS
);

    always_ff @(posedge clk) begin
        if (reset) begin
            hdump   <= '0;
            vdump   <= '0;
            vrender <= vpos_t'(1);
            hstart  <= 1'b0;
        end else begin
            hstart <= 1'b0;
            if (pxl_cen) begin
                if (hdump == hpos_t'(HTOTAL - 1)) begin
                    hdump  <= '0;
                    hstart <= 1'b1;
                    // vrender always runs one line ahead
                    vdump  <= vrender;
                    if (vrender == vpos_t'(VTOTAL - 1)) begin
                        vrender <= '0;
                    end else begin
                        vrender <= vrender + 1'b1;
                    end
                end else begin
                    hdump <= hdump + 1'b1;
                end
            end
        end
    end

    // Blanking signals are high in the visible area
    assign LHBL = hdump < hpos_t'(HACTIVE);
    assign LVBL = vdump < vpos_t'(VACTIVE);

    assign HS = hdump >= hpos_t'(HS_START) && hdump < hpos_t'(HS_END);
    assign VS = vdump >= vpos_t'(VS_START) && vdump <= vpos_t'(VS_END);

endmodule

`default_nettype wire

//--- verilog/char_fetch.sv
`default_nettype none

module char_fetch import video_pkg::*; (
    input  wire            clk,
    input  wire            reset,
    input  wire            hstart,
    input  wire vpos_t     vrender,
    output map_addr_t      map_addr,
    output logic           map_cs,
    input  wire map_word_t map_data,
    input  wire            map_ok,
    output char_addr_t     char_addr,
    output logic           char_cs,
    input  wire char_row_t char_data,
    input  wire            char_ok,
    linebuf_if.writer      lb
);

    typedef enum logic [1:0] {
        IDLE,
        MAP_RD,
        CHAR_RD,
        DRAW
    } state_t;

    state_t           state;
    logic [COL_W-1:0] col;
    logic [2:0]       px;
    vpos_t            line;
    logic [2:0]       pal;
    logic             hflip;
    char_row_t        row_sr;
    logic             last_px;
    logic             last_col;

    assign last_px  = px == 3'd7;
    assign last_col = col == COL_W'(TILE_COLS - 1);

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= IDLE;
            map_cs  <= 1'b0;
            char_cs <= 1'b0;
            col     <= '0;
            px      <= '0;
        end else begin
            case (state)
                IDLE: begin
                    // Lines in vertical blanking are not fetched
                    if (hstart && vrender < vpos_t'(VACTIVE)) begin
                        state  <= MAP_RD;
                        map_cs <= 1'b1;
                        col    <= '0;
                    end
                end
                MAP_RD: begin
                    if (map_ok) begin
                        map_cs  <= 1'b0;
                        char_cs <= 1'b1;
                        state   <= CHAR_RD;
                    end
                end
                CHAR_RD: begin
                    if (char_ok) begin
                        char_cs <= 1'b0;
                        px      <= '0;
                        state   <= DRAW;
                    end
                end
                DRAW: begin
                    px <= px + 1'b1;
                    if (last_px) begin
                        if (last_col) begin
                            state <= IDLE;
                        end else begin
                            col    <= col + 1'b1;
                            map_cs <= 1'b1;
                            state  <= MAP_RD;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Addresses and tile attributes
    always_ff @(posedge clk) begin
        if (state == IDLE && hstart) begin
            line     <= vrender;
            map_addr <= map_addr_t'(vrender[4:3] * TILE_COLS);
        end
        if (state == DRAW && last_px && !last_col) begin
            map_addr <= map_addr + 1'b1;
        end
        if (state == MAP_RD && map_ok) begin
            char_addr <= {map_data.code, line[2:0]};
            pal       <= map_data.pal;
            hflip     <= map_data.hflip;
        end
        if (state == CHAR_RD && char_ok) begin
            row_sr <= char_data;
        end else if (state == DRAW) begin
            row_sr <= row_sr << 4;
        end
    end

    // One pixel per clk, right to left when flipped
    assign lb.wr_en   = state == DRAW;
    assign lb.wr_addr = hpos_t'({col, hflip ? ~px : px});
    assign lb.wr_pix  = {pal, row_sr[31:28]};

endmodule

`default_nettype wire

//--- verilog/char_linebuf.sv
`default_nettype none

module char_linebuf import video_pkg::*; (
    input  wire      clk,
    input  wire      reset,
    input  wire      hstart,
    linebuf_if.store lb
);

    pix_t mem [0:1][0:HACTIVE-1];
    // Bank being written this line
    logic bank;

    always_ff @(posedge clk) begin
        if (reset) begin
            bank <= 1'b0;
        end else if (hstart) begin
            bank <= ~bank;
        end
    end

    // The mixer reads what was written during the previous line
    always_ff @(posedge clk) begin
        if (lb.wr_en) begin
            mem[bank][lb.wr_addr[LB_AW-1:0]] <= lb.wr_pix;
        end
        lb.rd_pix <= mem[~bank][lb.rd_addr[LB_AW-1:0]];
    end

endmodule

`default_nettype wire

//--- verilog/char_colmix.sv
`default_nettype none

module char_colmix import video_pkg::*; (
    input  wire          clk,
    input  wire          reset,
    input  wire          pxl_cen,
    input  wire hpos_t   hdump,
    input  wire          LHBL,
    input  wire          LVBL,
    input  wire          pal_we,
    input  wire pix_t    pal_addr,
    input  wire colour_t pal_din,
    linebuf_if.reader    lb,
    output logic [4:0]   red,
    output logic [4:0]   green,
    output logic [4:0]   blue,
    output logic         LHBL_dly,
    output logic         LVBL_dly
);

    colour_t pal_ram [0:PAL_SIZE-1];
    colour_t pal_rd;
    pix_t    pix_s1;
    logic    hbl_s1;
    logic    vbl_s1;

    assign lb.rd_addr = hdump;

    // CPU palette port and lookup
    always_ff @(posedge clk) begin
        if (pal_we) begin
            pal_ram[pal_addr] <= pal_din;
        end
        pal_rd <= pal_ram[pix_s1];
        if (pxl_cen) begin
            pix_s1 <= lb.rd_pix;
        end
    end

    // Two pixel stages from hdump to the RGB outputs
    always_ff @(posedge clk) begin
        if (reset) begin
            hbl_s1   <= 1'b0;
            vbl_s1   <= 1'b0;
            LHBL_dly <= 1'b0;
            LVBL_dly <= 1'b0;
            red      <= '0;
            green    <= '0;
            blue     <= '0;
        end else if (pxl_cen) begin
            hbl_s1   <= LHBL;
            vbl_s1   <= LVBL;
            LHBL_dly <= hbl_s1;
            LVBL_dly <= vbl_s1;
            // Nibble 0 is transparent
            if (hbl_s1 && vbl_s1 && pix_s1.nib != 4'd0) begin
                red   <= pal_rd.r;
                green <= pal_rd.g;
                blue  <= pal_rd.b;
            end else begin
                red   <= '0;
                green <= '0;
                blue  <= '0;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/char_video.sv
`default_nettype none

module char_video import video_pkg::*; (
    input  wire            clk,
    input  wire            reset,
    output wire            pxl2_cen,
    output wire            pxl_cen,
    output wire [4:0]      red,
    output wire [4:0]      green,
    output wire [4:0]      blue,
    output wire            LHBL_dly,
    output wire            LVBL_dly,
    output wire            HS,
    output wire            VS,
    // Tile map ROM
    output wire map_addr_t map_addr,
    output wire            map_cs,
    input  wire map_word_t map_data,
    input  wire            map_ok,
    // Character ROM
    output wire char_addr_t char_addr,
    output wire            char_cs,
    input  wire char_row_t char_data,
    input  wire            char_ok,
    // Palette write port
    input  wire            pal_we,
    input  wire pix_t      pal_addr,
    input  wire colour_t   pal_din
);

    wire hpos_t hdump;
    wire vpos_t vrender;
    wire        hstart;
    wire        LHBL;
    wire        LVBL;

    linebuf_if lb();

    video_cen u_cen(
        .clk        ( clk       ),
        .reset      ( reset     ),
        .pxl2_cen   ( pxl2_cen  ),
        .pxl_cen    ( pxl_cen   )
    );

    video_timing u_timing(
        .clk        ( clk       ),
        .reset      ( reset     ),
        .pxl_cen    ( pxl_cen   ),
        .hdump      ( hdump     ),
        .vdump      (           ),
        .vrender    ( vrender   ),
        .hstart     ( hstart    ),
        .LHBL       ( LHBL      ),
        .LVBL       ( LVBL      ),
        .HS         ( HS        ),
        .VS         ( VS        )
    );

    char_fetch u_fetch(
        .clk        ( clk       ),
        .reset      ( reset     ),
        .hstart     ( hstart    ),
        .vrender    ( vrender   ),
        .map_addr   ( map_addr  ),
        .map_cs     ( map_cs    ),
        .map_data   ( map_data  ),
        .map_ok     ( map_ok    ),
        .char_addr  ( char_addr ),
        .char_cs    ( char_cs   ),
        .char_data  ( char_data ),
        .char_ok    ( char_ok   ),
        .lb         ( lb.writer )
    );

    char_linebuf u_linebuf(
        .clk        ( clk       ),
        .reset      ( reset     ),
        .hstart     ( hstart    ),
        .lb         ( lb.store  )
    );

    char_colmix u_colmix(
        .clk        ( clk       ),
        .reset      ( reset     ),
        .pxl_cen    ( pxl_cen   ),
        .hdump      ( hdump     ),
        .LHBL       ( LHBL      ),
        .LVBL       ( LVBL      ),
        .pal_we     ( pal_we    ),
        .pal_addr   ( pal_addr  ),
        .pal_din    ( pal_din   ),
        .lb         ( lb.reader ),
        .red        ( red       ),
        .green      ( green     ),
        .blue       ( blue      ),
        .LHBL_dly   ( LHBL_dly  ),
        .LVBL_dly   ( LVBL_dly  )
    );

endmodule

`default_nettype wire

//--- tb/char_video_tb.sv
`default_nettype none

module char_video_tb import video_pkg::*; ();

    // Golden file sections
    localparam int MAP_BASE   = 'h000;
    localparam int MAP_WORDS  = 4;
    localparam int CHAR_BASE  = 'h010;
    localparam int CHAR_ROWS  = 32;
    localparam int PAL_BASE   = 'h030;
    localparam int PAL_WRITES = 12;
    localparam int EXP_BASE   = 'h040;
    localparam int FRAME_PIX  = HACTIVE * VACTIVE;
    localparam int LAT_MAX    = 12;
    // Three frames of clk plus one frame and the reset as margin
    localparam int FRAME_CLK  = HTOTAL * VTOTAL * 2 * CEN_DIV;
    localparam int WATCH_CLK  = 3 * FRAME_CLK + FRAME_CLK + 16;

    logic       clk = 1'b0;
    logic       reset;
    wire        pxl2_cen;
    wire        pxl_cen;
    wire [4:0]  red;
    wire [4:0]  green;
    wire [4:0]  blue;
    wire        LHBL_dly;
    wire        LVBL_dly;
    wire        HS;
    wire        VS;
    wire map_addr_t  map_addr;
    wire             map_cs;
    map_word_t       map_data;
    logic            map_ok;
    wire char_addr_t char_addr;
    wire             char_cs;
    char_row_t       char_data;
    logic            char_ok;
    logic            pal_we;
    pix_t            pal_addr;
    colour_t         pal_din;

    logic [31:0] golden [0:EXP_BASE+FRAME_PIX-1];
    int   errors    = 0;
    int   checks    = 0;
    int   frame     = 1;
    int   vis_count = 0;
    logic lvbl_prev = 1'b0;
    int   map_cnt;
    int   map_lat;
    int   char_cnt;
    int   char_lat;
    int   cen_edges;

    char_video u_dut(
        .clk        ( clk       ),
        .reset      ( reset     ),
        .pxl2_cen   ( pxl2_cen  ),
        .pxl_cen    ( pxl_cen   ),
        .red        ( red       ),
        .green      ( green     ),
        .blue       ( blue      ),
        .LHBL_dly   ( LHBL_dly  ),
        .LVBL_dly   ( LVBL_dly  ),
        .HS         ( HS        ),
        .VS         ( VS        ),
        .map_addr   ( map_addr  ),
        .map_cs     ( map_cs    ),
        .map_data   ( map_data  ),
        .map_ok     ( map_ok    ),
        .char_addr  ( char_addr ),
        .char_cs    ( char_cs   ),
        .char_data  ( char_data ),
        .char_ok    ( char_ok   ),
        .pal_we     ( pal_we    ),
        .pal_addr   ( pal_addr  ),
        .pal_din    ( pal_din   )
    );

    always #5 clk = ~clk;

    task automatic check_colour(input string name, input colour_t exp, input colour_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_blank(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic verify_level(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic verify_frame_size(input int frame_no, input int seen);
        checks++;
        if (seen != FRAME_PIX) begin
            errors++;
            $display("[FAIL] visible samples in frame %0d: expected %0d, actual %0d",
                     frame_no, FRAME_PIX, seen);
        end
    endtask

    // Map and character ROMs, ok comes 1 to LAT_MAX clk after cs rises
    initial begin : rom_models
        void'($urandom(82));
        forever begin
            @(negedge clk);
            if (reset || !map_cs) begin
                map_ok  <= 1'b0;
                map_cnt <= 1;
                map_lat <= $urandom_range(LAT_MAX, 1);
            end else if (!map_ok) begin
                if (map_cnt >= map_lat) begin
                    map_ok   <= 1'b1;
                    map_data <= map_addr < MAP_WORDS ?
                                map_word_t'(golden[MAP_BASE + map_addr][15:0]) : '0;
                end else begin
                    map_cnt <= map_cnt + 1;
                end
            end
            // Character ROM
            if (reset || !char_cs) begin
                char_ok  <= 1'b0;
                char_cnt <= 1;
                char_lat <= $urandom_range(LAT_MAX, 1);
            end else if (!char_ok) begin
                if (char_cnt >= char_lat) begin
                    char_ok   <= 1'b1;
                    char_data <= char_addr < CHAR_ROWS ? golden[CHAR_BASE + char_addr] : '0;
                end else begin
                    char_cnt <= char_cnt + 1;
                end
            end
        end
    end

    // Clock enables against the clk edges counted since reset fell
    always @(negedge clk) begin
        if (reset) begin
            cen_edges = 0;
        end else begin
            cen_edges++;
            verify_level("pxl2_cen", cen_edges % CEN_DIV == 0, pxl2_cen);
            verify_level("pxl_cen", cen_edges % (2 * CEN_DIV) == CEN_DIV, pxl_cen);
        end
    end

    // One sample per pixel, taken while pxl_cen is high and the outputs are settled
    always @(negedge clk) begin : sample_pixels
        colour_t seen;
        string   name;
        if (!reset && pxl_cen && frame <= 3) begin
            seen = {blue, green, red};
            if (LHBL_dly && LVBL_dly) begin
                if (frame >= 2 && vis_count < FRAME_PIX) begin
                    name = $sformatf("frame %0d line %0d pixel %0d", frame,
                                     vis_count / HACTIVE, vis_count % HACTIVE);
                    check_colour(name, colour_t'(golden[EXP_BASE + vis_count][14:0]), seen);
                end
                vis_count++;
            end else begin
                name = $sformatf("blanked rgb in frame %0d", frame);
                check_colour(name, '0, seen);
            end
            // End of the visible part of a frame
            if (lvbl_prev && !LVBL_dly) begin
                verify_frame_size(frame, vis_count);
                vis_count = 0;
                frame++;
            end
            lvbl_prev = LVBL_dly;
        end
    end

    initial begin
        #(WATCH_CLK * 10);
        $display("Timeout: frame 3 did not finish within %0d clk cycles", WATCH_CLK);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        int i;
        reset     = 1'b1;
        pal_we    = 1'b0;
        pal_addr  = '0;
        pal_din   = '0;
        map_data  = '0;
        map_ok    = 1'b0;
        char_data = '0;
        char_ok   = 1'b0;
        $readmemh("tb/golden_char_video.txt", golden);
        repeat (16) @(negedge clk);
        reset <= 1'b0;

        @(negedge clk);
        verify_level("map_cs after reset", 1'b0, map_cs);
        verify_level("char_cs after reset", 1'b0, char_cs);
        verify_level("HS after reset", 1'b0, HS);
        verify_level("VS after reset", 1'b0, VS);
        check_blank("LHBL_dly after reset", 1'b0, LHBL_dly);
        check_blank("LVBL_dly after reset", 1'b0, LVBL_dly);

        // Palette is loaded during frame 1
        for (i = 0; i < PAL_WRITES; i++) begin
            pal_we   <= 1'b1;
            pal_addr <= pix_t'(golden[PAL_BASE + i][22:16]);
            pal_din  <= colour_t'(golden[PAL_BASE + i][14:0]);
            @(negedge clk);
        end
        pal_we <= 1'b0;

        wait (frame > 3);
        @(negedge clk);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
verilog/video_pkg.sv
verilog/linebuf_if.sv
verilog/video_cen.sv
verilog/video_timing.sv
verilog/char_fetch.sv
verilog/char_linebuf.sv
verilog/char_colmix.sv
verilog/char_video.sv
tb/char_video_tb.sv

//--- tb/golden_char_video.txt
// @000 map words by map address, @010 character rows by char address
// @030 palette writes {addr[22:16], colour[14:0]}, @040 expected colours, 16 per visible line
@000
0200 8401 8602 0203
@010
01230123 12301230 23012301 30123012 32103210 21032103 10321032 03210321
12300000 01230000 00123000 00012300 00001230 00000123 30000012 23000001
10000000 21000000 32100000 03210000 00321000 00032100 00003210 00000321
11111111 22222222 33333333 00000000 12121212 23232323 31313131 10203010
@030
00107FFF 0011001F 001203E0 00137C00
00207FFF 00210010 00220200 00234000
00307FFF 00310421 00320842 00331084
@040
0000 001F 03E0 7C00 0000 001F 03E0 7C00 0000 0000 0000 0000 0000 4000 0200 0010
001F 03E0 7C00 0000 001F 03E0 7C00 0000 0000 0000 0000 0000 4000 0200 0010 0000
03E0 7C00 0000 001F 03E0 7C00 0000 001F 0000 0000 0000 4000 0200 0010 0000 0000
7C00 0000 001F 03E0 7C00 0000 001F 03E0 0000 0000 4000 0200 0010 0000 0000 0000
7C00 03E0 001F 0000 7C00 03E0 001F 0000 0000 4000 0200 0010 0000 0000 0000 0000
03E0 001F 0000 7C00 03E0 001F 0000 7C00 4000 0200 0010 0000 0000 0000 0000 0000
001F 0000 7C00 03E0 001F 0000 7C00 03E0 0200 0010 0000 0000 0000 0000 0000 4000
0000 7C00 03E0 001F 0000 7C00 03E0 001F 0010 0000 0000 0000 0000 0000 4000 0200
0000 0000 0000 0000 0000 0000 0000 0421 001F 001F 001F 001F 001F 001F 001F 001F
0000 0000 0000 0000 0000 0000 0421 0842 03E0 03E0 03E0 03E0 03E0 03E0 03E0 03E0
0000 0000 0000 0000 0000 0421 0842 1084 7C00 7C00 7C00 7C00 7C00 7C00 7C00 7C00
0000 0000 0000 0000 0421 0842 1084 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0421 0842 1084 0000 0000 001F 03E0 001F 03E0 001F 03E0 001F 03E0
0000 0000 0421 0842 1084 0000 0000 0000 03E0 7C00 03E0 7C00 03E0 7C00 03E0 7C00
0000 0421 0842 1084 0000 0000 0000 0000 7C00 001F 7C00 001F 7C00 001F 7C00 001F
0421 0842 1084 0000 0000 0000 0000 0000 001F 0000 03E0 0000 7C00 0000 001F 0000
